//--- Makefile
# Verilator build and run of the execute stage testbench

SIM := obj_dir/exeSim

.PHONY: compile run clean

compile:
	verilator --binary --assert --timescale 1ns/1ns -j 0 -f files.f --top-module exeTb -Mdir obj_dir -o exeSim

run: compile
	./$(SIM) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/exceptPkg.sv
// execute stage exception codes
package exceptPkg;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_OV,     // signed add/sub overflow
        EXC_ADEL,   // misaligned load
        EXC_ADES    // misaligned store
    } excCodeT;

endpackage

//--- common/exePkg.sv
// execute stage types
`include "exe_consts.svh"

package exePkg;

    typedef logic [`DATA_W-1:0] wordT;
    typedef logic [`REG_AW-1:0] regAddrT;

    // ops decoded in ID
    typedef enum logic [4:0] {
        ADD, ADDU, SUB, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLL, SRL, SRA,
        LUI,
        MULT, MULTU, DIV, DIVU,
        MFHI, MFLO, MTHI, MTLO,
        NOP
    } aluOpT;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLEZ,
        BR_BGTZ, BR_BLTZ, BR_BGEZ, BR_JUMP   // jumps always taken
    } brTypeT;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_LW, MEM_LH, MEM_LB, MEM_SW, MEM_SH, MEM_SB
    } memTypeT;

    // mult/div sequencer
    typedef enum logic [1:0] {
        IDLE, BUSY, DONE
    } mdStateT;

endpackage

//--- common/exe_consts.svh
// execute stage constants
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// datapath word
`define DATA_W     32
`define REG_AW     5   // 32 GPRs

// mult/div iterations, one bit per step
`define DIV_CYCLES 32

`endif

//--- files.f
+incdir+common
common/exePkg.sv
common/exceptPkg.sv
logic/exeReg.sv
logic/alu.sv
mulDiv/mulDiv.sv
mulDiv/hiLo.sv
logic/branchSolve.sv
logic/exceptCheck.sv
logic/exeTop.sv
verification/exeTb.sv

//--- logic/alu.sv
// execute stage ALU
`timescale 1ns/1ns
`include "exe_consts.svh"

module alu (
    input  exePkg::wordT  busA,
    input  exePkg::wordT  busB,
    input  exePkg::wordT  imm32,
    input  logic [4:0]    shamt,
    input  exePkg::aluOpT aluOp,
    input  logic          useImm,
    output exePkg::wordT  aluOut,
    output logic          overflow
);

    localparam int MSB = `DATA_W - 1;

    exePkg::wordT opB;
    exePkg::wordT sum;
    exePkg::wordT diff;

    assign opB  = useImm ? imm32 : busB;
    assign sum  = busA + opB;
    assign diff = busA - opB;

    always_comb begin
        case (aluOp)
            exePkg::ADD, exePkg::ADDU: aluOut = sum;
            exePkg::SUB, exePkg::SUBU: aluOut = diff;
            exePkg::AND:  aluOut = busA & opB;
            exePkg::OR:   aluOut = busA | opB;
            exePkg::XOR:  aluOut = busA ^ opB;
            exePkg::NOR:  aluOut = ~(busA | opB);
            exePkg::SLT:  aluOut = exePkg::wordT'($signed(busA) < $signed(opB));
            exePkg::SLTU: aluOut = exePkg::wordT'(busA < opB);
            exePkg::SLL:  aluOut = busB << shamt;   // shifts act on rt
            exePkg::SRL:  aluOut = busB >> shamt;
            exePkg::SRA:  aluOut = exePkg::wordT'($signed(busB) >>> shamt);
            exePkg::LUI:  aluOut = opB << 16;
            default:      aluOut = '0;              // HI/LO ops handled elsewhere
        endcase
    end

    // same-sign operands giving an opposite-sign result
    assign overflow = (aluOp == exePkg::ADD && busA[MSB] == opB[MSB] && sum[MSB] != busA[MSB])
                   || (aluOp == exePkg::SUB && busA[MSB] != opB[MSB] && diff[MSB] != busA[MSB]);

endmodule

//--- logic/branchSolve.sv
// branch resolution and misprediction check
`timescale 1ns/1ns

module branchSolve (
    input  logic           valid,
    input  exePkg::brTypeT brType,
    input  exePkg::wordT   busA,
    input  exePkg::wordT   busB,
    input  exePkg::wordT   pc,
    input  exePkg::wordT   brTarget,
    input  logic           predTaken,
    output logic           predFailed,
    output exePkg::wordT   corrVector
);

    logic taken;

    always_comb begin
        case (brType)
            exePkg::BR_BEQ:  taken = busA == busB;
            exePkg::BR_BNE:  taken = busA != busB;
            exePkg::BR_BLEZ: taken = $signed(busA) <= 0;
            exePkg::BR_BGTZ: taken = $signed(busA) > 0;
            exePkg::BR_BLTZ: taken = $signed(busA) < 0;
            exePkg::BR_BGEZ: taken = $signed(busA) >= 0;
            exePkg::BR_JUMP: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign predFailed = valid && brType != exePkg::BR_NONE && taken != predTaken;

    // fall through skips the delay slot
    assign corrVector = taken ? brTarget : pc + exePkg::wordT'(8);

endmodule

//--- logic/exceptCheck.sv
// execute stage exception detection
`timescale 1ns/1ns

module exceptCheck (
    input  logic               valid,
    input  logic               overflow,
    input  exePkg::memTypeT    memType,
    input  exePkg::wordT       aluOut,
    input  logic               regWr,
    input  logic               disWr,
    output exceptPkg::excCodeT excCode,
    output logic               finalRegWr,
    output exePkg::memTypeT    finalMemType
);

    logic misLoad;
    logic misStore;

    // aluOut is the effective address for loads and stores
    assign misLoad  = (memType == exePkg::MEM_LW && aluOut[1:0] != 2'b00)
                   || (memType == exePkg::MEM_LH && aluOut[0]);
    assign misStore = (memType == exePkg::MEM_SW && aluOut[1:0] != 2'b00)
                   || (memType == exePkg::MEM_SH && aluOut[0]);

    always_comb begin
        if (!valid)        excCode = exceptPkg::EXC_NONE;
        else if (overflow) excCode = exceptPkg::EXC_OV;
        else if (misLoad)  excCode = exceptPkg::EXC_ADEL;
        else if (misStore) excCode = exceptPkg::EXC_ADES;
        else               excCode = exceptPkg::EXC_NONE;
    end

    assign finalRegWr   = regWr && !disWr && excCode == exceptPkg::EXC_NONE;
    assign finalMemType = (disWr || excCode != exceptPkg::EXC_NONE) ? exePkg::MEM_NONE
                                                                     : memType;

endmodule

//--- logic/exeReg.sv
// ID/EXE pipeline register
`timescale 1ns/1ns

module exeReg (
    input  logic              clk,
    input  logic              arstN,
    input  logic              exeWr,
    input  logic              exeFlush,
    input  logic              idValid,
    input  exePkg::wordT      idPc,
    input  exePkg::wordT      idBusA,
    input  exePkg::wordT      idBusB,
    input  exePkg::wordT      idImm32,
    input  logic [4:0]        idShamt,
    input  exePkg::aluOpT     idAluOp,
    input  logic              idUseImm,
    input  exePkg::regAddrT   idDst,
    input  logic              idRegWr,
    input  exePkg::memTypeT   idMemType,
    input  exePkg::brTypeT    idBrType,
    input  exePkg::wordT      idBrTarget,
    input  logic              idPredTaken,
    output logic              valid,
    output exePkg::wordT      pc,
    output exePkg::wordT      busA,
    output exePkg::wordT      busB,
    output exePkg::wordT      imm32,
    output logic [4:0]        shamt,
    output exePkg::aluOpT     aluOp,
    output logic              useImm,
    output exePkg::regAddrT   dst,
    output logic              regWr,
    output exePkg::memTypeT   memType,
    output exePkg::brTypeT    brType,
    output exePkg::wordT      brTarget,
    output logic              predTaken
);

    logic load;

    assign load = exeWr && !exeFlush;   // flush wins

    // fields that make a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            valid   <= 1'b0;
            regWr   <= 1'b0;
            memType <= exePkg::MEM_NONE;
        end else if (exeFlush) begin
            valid   <= 1'b0;
            regWr   <= 1'b0;
            memType <= exePkg::MEM_NONE;
        end else if (exeWr) begin
            valid   <= idValid;
            regWr   <= idValid && idRegWr;
            memType <= idValid ? idMemType : exePkg::MEM_NONE;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aluOp     <= exePkg::NOP;
            brType    <= exePkg::BR_NONE;
            useImm    <= 1'b0;
            predTaken <= 1'b0;
            dst       <= '0;
        end else if (load) begin
            aluOp     <= idAluOp;
            brType    <= idBrType;
            useImm    <= idUseImm;
            predTaken <= idPredTaken;
            dst       <= idDst;
        end
    end

    // operands and addresses
    always_ff @(posedge clk) begin
        if (load) begin
            pc       <= idPc;
            busA     <= idBusA;
            busB     <= idBusB;
            imm32    <= idImm32;
            shamt    <= idShamt;
            brTarget <= idBrTarget;
        end
    end

    // a bubble never writes the register file or memory
    assert property (@(posedge clk) disable iff (!arstN)
        !valid |-> !regWr && memType == exePkg::MEM_NONE);

endmodule

//--- logic/exeTop.sv
// execute stage top
`timescale 1ns/1ns

module exeTop (
    input  logic               clk,
    input  logic               arstN,
    input  logic               exeWr,
    input  logic               exeFlush,
    input  logic               exeDisWr,
    input  logic               idValid,
    input  exePkg::wordT       idPc,
    input  exePkg::wordT       idBusA,
    input  exePkg::wordT       idBusB,
    input  exePkg::wordT       idImm32,
    input  logic [4:0]         idShamt,
    input  exePkg::aluOpT      idAluOp,
    input  logic               idUseImm,
    input  exePkg::regAddrT    idDst,
    input  logic               idRegWr,
    input  exePkg::memTypeT    idMemType,
    input  exePkg::brTypeT     idBrType,
    input  exePkg::wordT       idBrTarget,
    input  logic               idPredTaken,
    output logic               exeValid,
    output exePkg::wordT       exeResult,
    output exePkg::regAddrT    exeDst,
    output logic               exeRegWr,
    output exePkg::memTypeT    exeMemType,
    output exceptPkg::excCodeT exeExcCode,
    output logic               exePredFailed,
    output exePkg::wordT       exeCorrVector,
    output logic               exeMdStall
);

    exePkg::wordT    pc;
    exePkg::wordT    busA;
    exePkg::wordT    busB;
    exePkg::wordT    imm32;
    exePkg::wordT    brTarget;
    logic [4:0]      shamt;
    exePkg::aluOpT   aluOp;
    logic            useImm;
    logic            regWr;
    exePkg::memTypeT memType;
    exePkg::brTypeT  brType;
    logic            predTaken;
    exePkg::wordT    aluOut;
    logic            overflow;
    logic            mdFinish;
    exePkg::wordT    mdHi;
    exePkg::wordT    mdLo;
    exePkg::mdStateT mdState;
    logic            mdIssued;
    exePkg::wordT    hi;
    exePkg::wordT    lo;
    logic            hiWr;
    logic            loWr;

    exeReg i_exeReg (.*, .valid(exeValid), .dst(exeDst));

    alu i_alu (
        .busA     (busA),
        .busB     (busB),
        .imm32    (imm32),
        .shamt    (shamt),
        .aluOp    (aluOp),
        .useImm   (useImm),
        .aluOut   (aluOut),
        .overflow (overflow)
    );

    // set once the held instruction has finished, so it does not start again
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mdIssued <= 1'b0;
        end else if (exeFlush || exeWr) begin
            mdIssued <= 1'b0;
        end else if (mdFinish) begin
            mdIssued <= 1'b1;
        end
    end

    mulDiv i_mulDiv (
        .clk    (clk),
        .arstN  (arstN),
        .valid  (exeValid && !mdIssued),
        .aluOp  (aluOp),
        .busA   (busA),
        .busB   (busB),
        .abort  (exeFlush),
        .stall  (exeMdStall),
        .finish (mdFinish),
        .mdHi   (mdHi),
        .mdLo   (mdLo),
        .state  (mdState)
    );

    assign hiWr = exeValid && aluOp == exePkg::MTHI && !exeDisWr;
    assign loWr = exeValid && aluOp == exePkg::MTLO && !exeDisWr;

    hiLo i_hiLo (
        .clk    (clk),
        .arstN  (arstN),
        .finish (mdFinish && !exeDisWr),
        .hiWr   (hiWr),
        .loWr   (loWr),
        .wrData (busA),   // rs
        .mdHi   (mdHi),
        .mdLo   (mdLo),
        .state  (mdState),
        .hi     (hi),
        .lo     (lo)
    );

    branchSolve i_branchSolve (
        .valid      (exeValid),
        .brType     (brType),
        .busA       (busA),
        .busB       (busB),
        .pc         (pc),
        .brTarget   (brTarget),
        .predTaken  (predTaken),
        .predFailed (exePredFailed),
        .corrVector (exeCorrVector)
    );

    exceptCheck i_exceptCheck (
        .valid        (exeValid),
        .overflow     (overflow),
        .memType      (memType),
        .aluOut       (aluOut),
        .regWr        (regWr),
        .disWr        (exeDisWr),
        .excCode      (exeExcCode),
        .finalRegWr   (exeRegWr),
        .finalMemType (exeMemType)
    );

    // forwarded result
    always_comb begin
        if (aluOp == exePkg::MFHI) begin
            exeResult = hi;
        end else if (aluOp == exePkg::MFLO) begin
            exeResult = lo;
        end else if (brType == exePkg::BR_JUMP && regWr) begin
            exeResult = pc + exePkg::wordT'(8);   // link address
        end else begin
            exeResult = aluOut;
        end
    end

endmodule

//--- mulDiv/hiLo.sv
// HI/LO register pair
`timescale 1ns/1ns

module hiLo (
    input  logic            clk,
    input  logic            arstN,
    input  logic            finish,
    input  logic            hiWr,
    input  logic            loWr,
    input  exePkg::wordT    wrData,
    input  exePkg::wordT    mdHi,
    input  exePkg::wordT    mdLo,
    input  exePkg::mdStateT state,
    output exePkg::wordT    hi,
    output exePkg::wordT    lo
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hi <= '0;
            lo <= '0;
        end else if (finish) begin
            hi <= mdHi;     // product high or remainder
            lo <= mdLo;
        end else begin
            if (hiWr) hi <= wrData;   // MTHI
            if (loWr) lo <= wrData;   // MTLO
        end
    end

    // results only come out of the DONE state of the unit
    assert property (@(posedge clk) disable iff (!arstN) finish |-> state == exePkg::DONE);

endmodule

//--- mulDiv/mulDiv.sv
// iterative multiply/divide unit
`timescale 1ns/1ns
`include "exe_consts.svh"

module mulDiv (
    input  logic            clk,
    input  logic            arstN,
    input  logic            valid,
    input  exePkg::aluOpT   aluOp,
    input  exePkg::wordT    busA,
    input  exePkg::wordT    busB,
    input  logic            abort,
    output logic            stall,
    output logic            finish,
    output exePkg::wordT    mdHi,
    output exePkg::wordT    mdLo,
    output exePkg::mdStateT state
);

    localparam int W     = `DATA_W;
    localparam int CNT_W = $clog2(`DIV_CYCLES);

    logic             go;
    logic             isDiv;
    logic             isSigned;
    logic             negA;
    logic             negB;
    exePkg::wordT     absA;
    exePkg::wordT     absB;
    exePkg::wordT     hiReg;
    exePkg::wordT     loReg;
    exePkg::wordT     hiIn;
    exePkg::wordT     loIn;
    exePkg::wordT     hiNext;
    exePkg::wordT     loNext;
    logic [W:0]       addRes;
    logic [W:0]       trial;
    logic [2*W-1:0]   prod;
    logic [CNT_W-1:0] cnt;

    // operands stay in the stage register for the whole operation
    assign go       = valid && aluOp inside {exePkg::MULT, exePkg::MULTU,
                                             exePkg::DIV, exePkg::DIVU};
    assign isDiv    = aluOp inside {exePkg::DIV, exePkg::DIVU};
    assign isSigned = aluOp inside {exePkg::MULT, exePkg::DIV};
    assign negA     = isSigned && busA[W-1];
    assign negB     = isSigned && busB[W-1];
    assign absA     = negA ? -busA : busA;
    assign absB     = negB ? -busB : busB;

    // start cycle already performs step one
    assign hiIn = (state == exePkg::IDLE) ? '0 : hiReg;
    assign loIn = (state == exePkg::IDLE) ? absA : loReg;

    assign addRes = {1'b0, hiIn} + {1'b0, absB};
    assign trial  = {hiIn, loIn[W-1]} - {1'b0, absB};

    always_comb begin
        if (isDiv) begin
            if (!trial[W]) begin
                {hiNext, loNext} = {trial[W-1:0], loIn[W-2:0], 1'b1};   // subtract fits
            end else begin
                {hiNext, loNext} = {hiIn[W-2:0], loIn, 1'b0};           // restore
            end
        end else if (loIn[0]) begin
            {hiNext, loNext} = {addRes, loIn[W-1:1]};
        end else begin
            {hiNext, loNext} = {1'b0, hiIn, loIn[W-1:1]};
        end
    end

    assign stall  = (state == exePkg::IDLE && go) || state == exePkg::BUSY;
    assign finish = state == exePkg::DONE && !abort;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= exePkg::IDLE;
            cnt   <= '0;
        end else if (abort) begin
            state <= exePkg::IDLE;
        end else begin
            case (state)
                exePkg::IDLE: begin
                    if (go) begin
                        state <= exePkg::BUSY;
                        cnt   <= CNT_W'(1);
                    end
                end
                exePkg::BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`DIV_CYCLES - 1)) state <= exePkg::DONE;   // last step
                end
                default: state <= exePkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            hiReg <= hiNext;
            loReg <= loNext;
        end
    end

    // sign fixup of the magnitude result
    assign prod = {hiReg, loReg};

    always_comb begin
        if (isDiv) begin
            mdHi = negA ? -hiReg : hiReg;   // remainder follows dividend
            mdLo = (negA ^ negB) ? -loReg : loReg;
        end else begin
            {mdHi, mdLo} = (negA ^ negB) ? -prod : prod;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) finish |=> !finish);

endmodule

//--- verification/exeTb.sv
// execute stage testbench
`timescale 1ns/1ns
`include "exe_consts.svh"

module exeTb;

    localparam int NUM_ITER        = 300;
    localparam int WATCHDOG_CYCLES = 10 + NUM_ITER * 3 * (`DIV_CYCLES + 4);   // 3 instr per iter max

    logic               clk;
    logic               arstN;
    logic               exeWr;
    logic               exeFlush;
    logic               exeDisWr;
    logic               idValid;
    exePkg::wordT       idPc;
    exePkg::wordT       idBusA;
    exePkg::wordT       idBusB;
    exePkg::wordT       idImm32;
    logic [4:0]         idShamt;
    exePkg::aluOpT      idAluOp;
    logic               idUseImm;
    exePkg::regAddrT    idDst;
    logic               idRegWr;
    exePkg::memTypeT    idMemType;
    exePkg::brTypeT     idBrType;
    exePkg::wordT       idBrTarget;
    logic               idPredTaken;
    logic               exeValid;
    exePkg::wordT       exeResult;
    exePkg::regAddrT    exeDst;
    logic               exeRegWr;
    exePkg::memTypeT    exeMemType;
    exceptPkg::excCodeT exeExcCode;
    logic               exePredFailed;
    exePkg::wordT       exeCorrVector;
    logic               exeMdStall;

    // next instruction, kept as the model's copy of the stage register
    logic               nValid;
    exePkg::wordT       nPc;
    exePkg::wordT       nBusA;
    exePkg::wordT       nBusB;
    exePkg::wordT       nImm;
    logic [4:0]         nShamt;
    exePkg::aluOpT      nAluOp;
    logic               nUseImm;
    exePkg::regAddrT    nDst;
    logic               nRegWr;
    exePkg::memTypeT    nMem;
    exePkg::brTypeT     nBr;
    exePkg::wordT       nTarget;
    logic               nPred;
    logic               nDis;
    exePkg::wordT       mHi;   // model HI/LO
    exePkg::wordT       mLo;
    integer             seed = 3839;

    exeTop i_exeTop (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
        $display("test failed");
        $fatal(1);
    end

    function automatic int randBelow(int n);
        return int'(($random(seed) & 32'h7fff_ffff) % n);
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %s got %h expected %h", name, got, want);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic exePkg::wordT aluModel(exePkg::aluOpT op, exePkg::wordT a,
                                             exePkg::wordT b, exePkg::wordT opB,
                                             logic [4:0] sh);
        case (op)
            exePkg::ADD, exePkg::ADDU: return a + opB;
            exePkg::SUB, exePkg::SUBU: return a - opB;
            exePkg::AND:  return a & opB;
            exePkg::OR:   return a | opB;
            exePkg::XOR:  return a ^ opB;
            exePkg::NOR:  return ~(a | opB);
            exePkg::SLT:  return ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
            exePkg::SLTU: return (a < opB) ? 32'd1 : 32'd0;
            exePkg::SLL:  return b << sh;   // rt is shifted
            exePkg::SRL:  return b >> sh;
            exePkg::SRA:  return $signed(b) >>> sh;
            exePkg::LUI:  return {opB[15:0], 16'h0000};
            default:      return '0;
        endcase
    endfunction

    function automatic logic branchTaken(exePkg::brTypeT br, exePkg::wordT a, exePkg::wordT b);
        case (br)
            exePkg::BR_BEQ:  return a == b;
            exePkg::BR_BNE:  return a != b;
            exePkg::BR_BLEZ: return a[31] || (a == '0);
            exePkg::BR_BGTZ: return !a[31] && (a != '0);
            exePkg::BR_BLTZ: return a[31];
            exePkg::BR_BGEZ: return !a[31];
            exePkg::BR_JUMP: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    task automatic randomFields();
        nValid  = 1'b1;
        nPc     = $random(seed) & 32'hffff_fffc;
        nBusA   = $random(seed);
        nBusB   = $random(seed);
        nImm    = $random(seed);
        nShamt  = 5'($random(seed));
        nAluOp  = exePkg::NOP;
        nUseImm = 1'($random(seed));
        nDst    = exePkg::regAddrT'($random(seed));
        nRegWr  = 1'b1;
        nMem    = exePkg::MEM_NONE;
        nBr     = exePkg::BR_NONE;
        nTarget = $random(seed) & 32'hffff_fffc;
        nPred   = 1'($random(seed));
        nDis    = 1'b0;
    endtask

    // one capture edge, then sample in the middle of the EXE cycle
    task automatic driveInstr();
        @(posedge clk);
        exeWr       <= 1'b1;
        idValid     <= nValid;
        idPc        <= nPc;
        idBusA      <= nBusA;
        idBusB      <= nBusB;
        idImm32     <= nImm;
        idShamt     <= nShamt;
        idAluOp     <= nAluOp;
        idUseImm    <= nUseImm;
        idDst       <= nDst;
        idRegWr     <= nRegWr;
        idMemType   <= nMem;
        idBrType    <= nBr;
        idBrTarget  <= nTarget;
        idPredTaken <= nPred;
        @(posedge clk);
        exeWr    <= 1'b0;
        exeDisWr <= nDis;   // held until the next capture
        @(negedge clk);
    endtask

    task automatic mulDivModel();
        longint      sA;
        longint      sB;
        logic [63:0] res;

        sA = longint'($signed(nBusA));
        sB = longint'($signed(nBusB));
        case (nAluOp)
            exePkg::MULT:  res = 64'(sA * sB);
            exePkg::MULTU: res = {32'h0, nBusA} * {32'h0, nBusB};
            exePkg::DIV:   res = {32'(sA % sB), 32'(sA / sB)};
            default:       res = {nBusA % nBusB, nBusA / nBusB};
        endcase
        {mHi, mLo} = res;
    endtask

    task automatic runInstr();
        exePkg::wordT       opB;
        exePkg::wordT       aluV;
        exePkg::wordT       expRes;
        exceptPkg::excCodeT expExc;
        exePkg::memTypeT    expMem;
        longint             sA;
        longint             sB;
        logic               ov;
        logic               taken;
        logic               misLoad;
        logic               misStore;
        logic               expStall;
        int                 stallCycles;

        driveInstr();
        opB   = nUseImm ? nImm : nBusB;
        aluV  = aluModel(nAluOp, nBusA, nBusB, opB, nShamt);
        sA    = longint'($signed(nBusA));
        sB    = longint'($signed(opB));
        ov    = (nAluOp == exePkg::ADD && sA + sB != longint'($signed(aluV)))
             || (nAluOp == exePkg::SUB && sA - sB != longint'($signed(aluV)));
        taken = branchTaken(nBr, nBusA, nBusB);
        misLoad  = (nMem == exePkg::MEM_LW && aluV[1:0] != 2'b00)
                || (nMem == exePkg::MEM_LH && aluV[0]);
        misStore = (nMem == exePkg::MEM_SW && aluV[1:0] != 2'b00)
                || (nMem == exePkg::MEM_SH && aluV[0]);
        if (!nValid)       expExc = exceptPkg::EXC_NONE;
        else if (ov)       expExc = exceptPkg::EXC_OV;
        else if (misLoad)  expExc = exceptPkg::EXC_ADEL;
        else if (misStore) expExc = exceptPkg::EXC_ADES;
        else               expExc = exceptPkg::EXC_NONE;
        expMem = (!nValid || nDis || expExc != exceptPkg::EXC_NONE) ? exePkg::MEM_NONE : nMem;
        if (nAluOp == exePkg::MFHI)                          expRes = mHi;
        else if (nAluOp == exePkg::MFLO)                     expRes = mLo;
        else if (nBr == exePkg::BR_JUMP && nValid && nRegWr) expRes = nPc + 32'd8;
        else                                                 expRes = aluV;
        expStall = nValid && (nAluOp inside {exePkg::MULT, exePkg::MULTU,
                                             exePkg::DIV, exePkg::DIVU});

        checkVal("exeValid", 32'(exeValid), 32'(nValid));
        checkVal("exeDst", 32'(exeDst), 32'(nDst));
        checkVal("exeResult", exeResult, expRes);
        checkVal("exeExcCode", 32'(exeExcCode), 32'(expExc));
        checkVal("exeRegWr", 32'(exeRegWr),
                 32'(nValid && nRegWr && !nDis && expExc == exceptPkg::EXC_NONE));
        checkVal("exeMemType", 32'(exeMemType), 32'(expMem));
        checkVal("exePredFailed", 32'(exePredFailed),
                 32'(nValid && nBr != exePkg::BR_NONE && taken != nPred));
        checkVal("exeCorrVector", exeCorrVector, taken ? nTarget : nPc + 32'd8);
        checkVal("exeMdStall", 32'(exeMdStall), 32'(expStall));

        if (expStall) begin
            stallCycles = 0;
            while (exeMdStall) begin
                stallCycles++;
                @(negedge clk);
            end
            checkVal("mdStallCycles", 32'(stallCycles), 32'(`DIV_CYCLES));
            if (!nDis) mulDivModel();
        end else if (nValid && !nDis && nAluOp == exePkg::MTHI) begin
            mHi = nBusA;
        end else if (nValid && !nDis && nAluOp == exePkg::MTLO) begin
            mLo = nBusA;
        end
    endtask

    task automatic readHiLo();
        randomFields();
        nAluOp = exePkg::MFHI;
        runInstr();
        randomFields();
        nAluOp = exePkg::MFLO;
        runInstr();
    endtask

    // a bubble must come out even with a capture pending
    task automatic flushStage();
        @(posedge clk);
        exeFlush <= 1'b1;
        exeWr    <= 1'b1;
        idValid  <= 1'b1;
        idRegWr  <= 1'b1;
        @(posedge clk);
        exeFlush <= 1'b0;
        exeWr    <= 1'b0;
        @(negedge clk);
        checkVal("exeValid", 32'(exeValid), 32'd0);
        checkVal("exeRegWr", 32'(exeRegWr), 32'd0);
        checkVal("exeMemType", 32'(exeMemType), 32'(exePkg::MEM_NONE));
        checkVal("exePredFailed", 32'(exePredFailed), 32'd0);
    endtask

    task automatic abortMulDiv();
        driveInstr();
        checkVal("exeMdStall", 32'(exeMdStall), 32'd1);
        repeat (randBelow(20)) @(negedge clk);
        @(posedge clk);
        exeFlush <= 1'b1;
        @(posedge clk);
        exeFlush <= 1'b0;
        @(negedge clk);
        checkVal("exeValid", 32'(exeValid), 32'd0);
        checkVal("exeRegWr", 32'(exeRegWr), 32'd0);
        checkVal("exeMdStall", 32'(exeMdStall), 32'd0);
    endtask

    initial begin
        int kind;

        arstN       = 1'b0;
        exeWr       = 1'b0;
        exeFlush    = 1'b0;
        exeDisWr    = 1'b0;
        idValid     = 1'b0;
        idPc        = '0;
        idBusA      = '0;
        idBusB      = '0;
        idImm32     = '0;
        idShamt     = '0;
        idAluOp     = exePkg::NOP;
        idUseImm    = 1'b0;
        idDst       = '0;
        idRegWr     = 1'b0;
        idMemType   = exePkg::MEM_NONE;
        idBrType    = exePkg::BR_NONE;
        idBrTarget  = '0;
        idPredTaken = 1'b0;
        mHi         = '0;
        mLo         = '0;

        repeat (9) @(posedge clk);
        @(negedge clk);
        checkVal("exeValid", 32'(exeValid), 32'd0);
        checkVal("exeRegWr", 32'(exeRegWr), 32'd0);
        checkVal("exeMdStall", 32'(exeMdStall), 32'd0);
        checkVal("exePredFailed", 32'(exePredFailed), 32'd0);
        checkVal("exeMemType", 32'(exeMemType), 32'(exePkg::MEM_NONE));
        checkVal("exeExcCode", 32'(exeExcCode), 32'(exceptPkg::EXC_NONE));
        @(posedge clk);
        arstN <= 1'b1;

        readHiLo();   // zero out of reset

        for (int i = 0; i < NUM_ITER; i++) begin
            kind = randBelow(8);
            randomFields();
            case (kind)
                0, 1, 2: begin
                    nAluOp = exePkg::aluOpT'(randBelow(14));   // ADD through LUI
                    nDis   = randBelow(8) == 0;
                    runInstr();
                end
                3: begin
                    nAluOp = exePkg::aluOpT'(int'(exePkg::MULT) + randBelow(4));
                    nRegWr = 1'b0;
                    if (nBusB == '0)
                        nBusB = 32'd1;
                    if (randBelow(4) == 0)
                        abortMulDiv();
                    else
                        runInstr();
                    readHiLo();
                end
                4: begin
                    nAluOp = (randBelow(2) == 0) ? exePkg::MTHI : exePkg::MTLO;
                    nRegWr = 1'b0;
                    nDis   = randBelow(4) == 0;
                    runInstr();
                    readHiLo();
                end
                5: begin
                    nAluOp = exePkg::ADDU;
                    nBr    = exePkg::brTypeT'(1 + randBelow(7));
                    if (randBelow(2) == 0)
                        nBusB = nBusA;
                    if (randBelow(4) == 0)
                        nBusA = '0;
                    nRegWr = nBr == exePkg::BR_JUMP && randBelow(2) == 0;   // JAL style link
                    runInstr();
                end
                6: begin
                    nAluOp  = exePkg::ADDU;
                    nUseImm = 1'b1;
                    nImm    = 32'(randBelow(64));
                    nMem    = exePkg::memTypeT'(1 + randBelow(6));
                    nRegWr  = nMem inside {exePkg::MEM_LW, exePkg::MEM_LH, exePkg::MEM_LB};
                    nDis    = randBelow(8) == 0;
                    runInstr();
                end
                default: begin
                    nAluOp = exePkg::aluOpT'(randBelow(14));
                    if (randBelow(2) == 0) begin
                        nValid = 1'b0;
                        runInstr();
                    end else begin
                        runInstr();
                        flushStage();
                    end
                end
            endcase
        end

        $display("test passed");
        $finish;
    end

endmodule
